// File: src/video_rotate_pkg.sv
// Widths and sizes shared by the rotation back end.
// One pixel occupies one 32-bit word in memory with the colour in bits 23:0.
// Each buffer spans 8 MB, so a buffer holds at most 2M pixels.
// Dimensions are limited to 4095 pixels per line and 4092 lines per frame.

package video_rotate_pkg;

	// Expanded pixel as {blue, green, red}, 8 bits each
	localparam int PIX_W = 24;

	// Wishbone data word, pixel in the low bits
	localparam int WORD_W = 32;

	// Word offset inside one buffer
	localparam int OFS_W = 21;

	// Line length and line count
	localparam int DIM_W = 12;

	// Index of one of the three buffers
	localparam int BUF_W = 2;

	// Wishbone byte address
	localparam int ADR_W = 32;

	// Byte size of one buffer
	localparam logic [ADR_W-1:0] BUF_BYTES = 32'h0080_0000;

endpackage

// File: src/sync_polarity_fix.sv
// Turns a sync of unknown polarity into an active-high sync.
// The polarity is decided from the previous period, so the first period
// after reset passes through unchanged.
// A period must be shorter than 2^24 clocks.

`timescale 1ns/1ps

module sync_polarity_fix (
	input  logic CLK_VIDEO,
	input  logic i_rst_n,
	input  logic i_sync,
	output logic o_sync
);

	localparam int CNT_W = 24;

	logic [CNT_W-1:0] cnt_hi;
	logic [CNT_W-1:0] cnt_lo;
	logic             sync_d;
	logic             invert;

	// A period runs from one rising edge of the raw input to the next
	always_ff @(posedge CLK_VIDEO) begin
		if (!i_rst_n) begin
			cnt_hi <= '0;
			cnt_lo <= '0;
			sync_d <= 1'b0;
			invert <= 1'b0;
		end else begin
			sync_d <= i_sync;
			if (i_sync && !sync_d) begin
				// The shorter phase is the pulse, so a long high phase means active low
				invert <= (cnt_hi > cnt_lo);
				cnt_hi <= {{(CNT_W-1){1'b0}}, 1'b1};
				cnt_lo <= '0;
			end else if (i_sync) begin
				cnt_hi <= cnt_hi + 1'b1;
			end else begin
				cnt_lo <= cnt_lo + 1'b1;
			end
		end
	end

	assign o_sync = i_sync ^ invert;

	// A wrapped counter would give a wrong polarity for the next period
	a_no_wrap: assert property (@(posedge CLK_VIDEO) disable iff (!i_rst_n)
		!(&cnt_hi) && !(&cnt_lo));

endmodule

// File: src/pixel_capture.sv
// Samples the native video stream on each rising edge of the pixel enable.
// DW selects the colour packing and must be 6, 8, 9, 12 or 24.
// The input colour holds red in the top bits and blue in the bottom bits.
// HS and VS must already be active high.
// The strobe is one clock wide and follows the sampling edge by one clock.

`timescale 1ns/1ps

module pixel_capture #(
	parameter int DW = 8
) (
	input  logic                              CLK_VIDEO,
	input  logic                              i_rst_n,
	input  logic                              i_ce_pix,
	input  logic [DW-1:0]                     i_rgb,
	input  logic                              i_hblank,
	input  logic                              i_vblank,
	input  logic                              i_hs,
	input  logic                              i_vs,
	output logic                              o_pix_stb,
	output logic [video_rotate_pkg::PIX_W-1:0] o_rgb,
	output logic                              o_hs,
	output logic                              o_vs,
	output logic                              o_de
);

	// Red and green share one width and blue takes the rest
	localparam int RG_W = (DW == 24) ? 8 : (DW == 12) ? 4 : (DW == 6) ? 2 : 3;
	localparam int B_W  = DW - 2 * RG_W;

	logic          ce_d;
	logic          hbl_q;
	logic          vbl_q;
	logic [DW-1:0] rgb_q;
	logic [7:0]    r_raw;
	logic [7:0]    g_raw;
	logic [7:0]    b_raw;

	// Fills 8 bits by repeating the n channel bits from the MSB down
	function automatic logic [7:0] expand(input logic [7:0] v, input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < 8; i++) begin
			r[7-i] = v[n-1-(i%n)];
		end
		return r;
	endfunction

	//============================================================
	// Sampling
	//============================================================

	always_ff @(posedge CLK_VIDEO) begin
		if (!i_rst_n) begin
			ce_d      <= 1'b0;
			o_pix_stb <= 1'b0;
			o_hs      <= 1'b0;
			o_vs      <= 1'b0;
			hbl_q     <= 1'b1;
			vbl_q     <= 1'b1;
		end else begin
			ce_d      <= i_ce_pix;
			o_pix_stb <= i_ce_pix && !ce_d;
			if (i_ce_pix && !ce_d) begin
				o_hs  <= i_hs;
				hbl_q <= i_hblank;
				// VS moves only at the start of a line sync
				if (!o_hs && i_hs)
					o_vs <= i_vs;
				// VBlank moves only where the active part of a line starts
				if (hbl_q && !i_hblank)
					vbl_q <= i_vblank;
			end
		end
	end

	// Colour is taken at the same sampling edge as the flags
	always_ff @(posedge CLK_VIDEO) begin
		if (i_ce_pix && !ce_d)
			rgb_q <= i_rgb;
	end

	//============================================================
	// Colour expansion
	//============================================================

	assign r_raw = 8'(rgb_q[DW-1 -: RG_W]);
	assign g_raw = 8'(rgb_q[B_W+RG_W-1 -: RG_W]);
	assign b_raw = 8'(rgb_q[B_W-1:0]);

	assign o_rgb = {expand(b_raw, B_W), expand(g_raw, RG_W), expand(r_raw, RG_W)};
	assign o_de  = !hbl_q && !vbl_q;

	a_dw_legal: assert property (@(posedge CLK_VIDEO) DW inside {6, 8, 9, 12, 24});

endmodule

// File: src/frame_measure.sv
// Measures the visible frame size from the captured stream.
// Sizes are latched at the rising edge of VS and so describe the previous frame.
// Until a frame with visible lines has been seen the size stays at 320 by 240.
// The stride is the line count rounded up to 4 words.

`timescale 1ns/1ps

module frame_measure (
	input  logic                              CLK_VIDEO,
	input  logic                              i_rst_n,
	input  logic                              i_pix_stb,
	input  logic                              i_vs,
	input  logic                              i_de,
	output logic [video_rotate_pkg::DIM_W-1:0] o_line_len,
	output logic [video_rotate_pkg::DIM_W-1:0] o_line_cnt,
	output logic [video_rotate_pkg::DIM_W-1:0] o_stride_words,
	output logic [video_rotate_pkg::OFS_W-1:0] o_buf_words
);

	localparam int DIM_W = video_rotate_pkg::DIM_W;
	localparam logic [DIM_W-1:0] DEF_LEN = 12'd320;
	localparam logic [DIM_W-1:0] DEF_CNT = 12'd240;

	logic             vs_d;
	logic             de_d;
	logic [DIM_W-1:0] hcnt;
	logic [DIM_W-1:0] vcnt;
	logic [DIM_W-1:0] len_meas;
	logic [DIM_W-1:0] cnt_up;

	always_ff @(posedge CLK_VIDEO) begin
		if (!i_rst_n) begin
			vs_d       <= 1'b0;
			de_d       <= 1'b0;
			hcnt       <= '0;
			vcnt       <= '0;
			len_meas   <= DEF_LEN;
			o_line_len <= DEF_LEN;
			o_line_cnt <= DEF_CNT;
		end else if (i_pix_stb) begin
			vs_d <= i_vs;
			de_d <= i_de;
			if (i_de)
				hcnt <= hcnt + 1'b1;
			// The end of the active part closes one line
			if (de_d && !i_de) begin
				len_meas <= hcnt;
				vcnt     <= vcnt + 1'b1;
				hcnt     <= '0;
			end
			if (i_vs && !vs_d) begin
				// A VS with no lines before it keeps the current size
				if (vcnt != '0) begin
					o_line_len <= len_meas;
					o_line_cnt <= vcnt;
				end
				vcnt <= '0;
			end
		end
	end

	assign cnt_up         = o_line_cnt + 2'd3;
	assign o_stride_words = {cnt_up[DIM_W-1:2], 2'b00};
	assign o_buf_words    = o_line_len * o_stride_words;

endmodule

// File: src/rotate_addr_gen.sv
// Maps every visible pixel to its word offset in the rotated buffer.
// Geometry comes from the previous frame, so a frame whose size changes
// is placed with the old size.
// The direction is taken at the rising edge of VS and holds for the frame.
// An entry is pushed one clock after the pixel strobe.

`timescale 1ns/1ps

module rotate_addr_gen (
	input  logic                              CLK_VIDEO,
	input  logic                              i_rst_n,
	input  logic                              i_pix_stb,
	input  logic [video_rotate_pkg::PIX_W-1:0] i_rgb,
	input  logic                              i_vs,
	input  logic                              i_de,
	input  logic                              i_rotate_ccw,
	input  logic [video_rotate_pkg::DIM_W-1:0] i_line_len,
	input  logic [video_rotate_pkg::DIM_W-1:0] i_line_cnt,
	input  logic [video_rotate_pkg::DIM_W-1:0] i_stride_words,
	output logic                              o_push,
	output logic [video_rotate_pkg::OFS_W-1:0] o_push_ofs,
	output logic [video_rotate_pkg::PIX_W-1:0] o_push_rgb
);

	localparam int DIM_W = video_rotate_pkg::DIM_W;
	localparam int OFS_W = video_rotate_pkg::OFS_W;

	logic             vs_d;
	logic             de_d;
	logic             ccw_q;
	logic [DIM_W-1:0] y;
	logic [DIM_W-1:0] col;
	logic [OFS_W-1:0] col_ext;
	logic [OFS_W-1:0] stride_ext;
	logic [OFS_W-1:0] last_row;
	logic [OFS_W-1:0] start_ofs;
	logic [OFS_W-1:0] run_ofs;
	logic [OFS_W-1:0] cur_ofs;

	// Input line y becomes output column H-1-y clockwise and y counter-clockwise
	assign col        = ccw_q ? y : i_line_cnt - 1'b1 - y;
	assign col_ext    = {{(OFS_W-DIM_W){1'b0}}, col};
	assign stride_ext = {{(OFS_W-DIM_W){1'b0}}, i_stride_words};

	// Counter-clockwise lines start on the last output row and walk upward
	assign last_row  = (i_line_len - 1'b1) * i_stride_words;
	assign start_ofs = ccw_q ? last_row + col_ext : col_ext;

	// The first pixel of a line starts fresh and later pixels step by one stride
	assign cur_ofs = (i_de && !de_d) ? start_ofs : run_ofs;

	always_ff @(posedge CLK_VIDEO) begin
		if (!i_rst_n) begin
			vs_d   <= 1'b0;
			de_d   <= 1'b0;
			ccw_q  <= 1'b0;
			y      <= '0;
			o_push <= 1'b0;
		end else begin
			o_push <= i_pix_stb && i_de;
			if (i_pix_stb) begin
				vs_d <= i_vs;
				de_d <= i_de;
				if (i_vs && !vs_d) begin
					y     <= '0;
					ccw_q <= i_rotate_ccw;
				end else if (de_d && !i_de) begin
					y <= y + 1'b1;
				end
			end
		end
	end

	// The entry for this pixel and the running offset of the next one in the line
	always_ff @(posedge CLK_VIDEO) begin
		if (i_pix_stb && i_de) begin
			o_push_ofs <= cur_ofs;
			o_push_rgb <= i_rgb;
			run_ofs    <= ccw_q ? cur_ofs - stride_ext : cur_ofs + stride_ext;
		end
	end

endmodule

// File: src/pixel_fifo.sv
// Show-ahead FIFO between the pixel stream and the bus master.
// FIFO_DEPTH must be a power of two.
// A push into a full FIFO is dropped even when a pop happens in the same cycle.
// The overflow flag is sticky until reset.

`timescale 1ns/1ps

module pixel_fifo #(
	parameter int WIDTH      = 45,
	parameter int FIFO_DEPTH = 16
) (
	input  logic             CLK_VIDEO,
	input  logic             i_rst_n,
	input  logic             i_push,
	input  logic [WIDTH-1:0] i_data,
	input  logic             i_pop,
	output logic [WIDTH-1:0] o_data,
	output logic             o_empty,
	output logic             o_overflow
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [WIDTH-1:0] mem [FIFO_DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full    = (count == FIFO_DEPTH);
	assign o_empty = (count == '0);
	assign do_push = i_push && !full;
	assign do_pop  = i_pop && !o_empty;
	assign o_data  = mem[rd_ptr];

	always_ff @(posedge CLK_VIDEO) begin
		if (!i_rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + do_push - do_pop;
			// Video cannot stall, so a lost pixel is only recorded
			if (i_push && full)
				o_overflow <= 1'b1;
		end
	end

	always_ff @(posedge CLK_VIDEO) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

	// The master must look at the empty flag before it pops
	a_no_pop_empty: assert property (@(posedge CLK_VIDEO) disable iff (!i_rst_n)
		i_pop |-> !o_empty);
	a_count_bound: assert property (@(posedge CLK_VIDEO) disable iff (!i_rst_n)
		count <= FIFO_DEPTH);

endmodule

// File: src/wb_pixel_writer.sv
// Wishbone classic master that writes one pixel word per bus cycle.
// An entry is {word offset, colour} and the buffer index is taken at the pop.
// CYC and STB drop for at least one clock after each acknowledge.
// The slave must acknowledge every cycle, as there is no error or retry.

`timescale 1ns/1ps

module wb_pixel_writer #(
	parameter logic [video_rotate_pkg::ADR_W-1:0] MEM_BASE = 32'h2400_0000
) (
	input  logic                                                   CLK_VIDEO,
	input  logic                                                   i_rst_n,
	input  logic                                                   i_empty,
	input  logic [video_rotate_pkg::OFS_W+video_rotate_pkg::PIX_W-1:0] i_data,
	input  logic [video_rotate_pkg::BUF_W-1:0]                     i_buf_idx,
	output logic                                                   o_pop,
	output logic                                                   o_wb_cyc,
	output logic                                                   o_wb_stb,
	output logic                                                   o_wb_we,
	output logic [video_rotate_pkg::WORD_W/8-1:0]                  o_wb_sel,
	output logic [video_rotate_pkg::ADR_W-1:0]                     o_wb_adr,
	output logic [video_rotate_pkg::WORD_W-1:0]                    o_wb_dat,
	input  logic                                                   i_wb_ack
);

	localparam int PIX_W  = video_rotate_pkg::PIX_W;
	localparam int OFS_W  = video_rotate_pkg::OFS_W;
	localparam int BUF_W  = video_rotate_pkg::BUF_W;
	localparam int ADR_W  = video_rotate_pkg::ADR_W;
	localparam int WORD_W = video_rotate_pkg::WORD_W;

	logic             busy;
	logic [ADR_W-1:0] buf_base;
	logic [ADR_W-1:0] ofs_bytes;

	assign buf_base  = {{(ADR_W-BUF_W){1'b0}}, i_buf_idx} * video_rotate_pkg::BUF_BYTES;
	assign ofs_bytes = {{(ADR_W-OFS_W-2){1'b0}}, i_data[PIX_W +: OFS_W], 2'b00};

	// A new entry is taken only while no bus cycle is open
	assign o_pop = !busy && !i_empty;

	always_ff @(posedge CLK_VIDEO) begin
		if (!i_rst_n)
			busy <= 1'b0;
		else if (o_pop)
			busy <= 1'b1;
		else if (i_wb_ack)
			busy <= 1'b0;
	end

	// Address and data are held unchanged for the whole bus cycle
	always_ff @(posedge CLK_VIDEO) begin
		if (o_pop) begin
			o_wb_adr <= MEM_BASE + buf_base + ofs_bytes;
			o_wb_dat <= {{(WORD_W-PIX_W){1'b0}}, i_data[PIX_W-1:0]};
		end
	end

	assign o_wb_cyc = busy;
	assign o_wb_stb = busy;
	assign o_wb_we  = busy;
	assign o_wb_sel = {(WORD_W/8){busy}};

	// An acknowledge may only answer a strobe inside an open cycle
	a_ack_in_cycle: assert property (@(posedge CLK_VIDEO) disable iff (!i_rst_n)
		i_wb_ack |-> o_wb_cyc && o_wb_stb);

endmodule

// File: src/fb_buffer_select.sv
// Buffer index handling between the writer and the scanout side.
// Triple mode keeps the written and the shown buffer apart at all times.
// Low-latency mode alternates between buffers 0 and 1 only.
// Both edges are detected on CLK_VIDEO, so i_fb_vbl must be synchronous to it.

`timescale 1ns/1ps

module fb_buffer_select #(
	parameter logic [video_rotate_pkg::ADR_W-1:0] MEM_BASE = 32'h2400_0000
) (
	input  logic                              CLK_VIDEO,
	input  logic                              i_rst_n,
	input  logic                              i_vs,
	input  logic                              i_fb_vbl,
	input  logic                              i_low_lat,
	output logic [video_rotate_pkg::BUF_W-1:0] o_wr_buf,
	output logic [video_rotate_pkg::ADR_W-1:0] o_fb_base
);

	localparam int BUF_W = video_rotate_pkg::BUF_W;
	localparam int ADR_W = video_rotate_pkg::ADR_W;

	logic [BUF_W-1:0] rd_buf;
	logic             vs_d;
	logic             vbl_d;

	// Returns the buffer held by neither index
	function automatic logic [BUF_W-1:0] third_buf(input logic [BUF_W-1:0] a,
		input logic [BUF_W-1:0] b);
		logic [BUF_W-1:0] n;
		if (a == b)
			n = (a == 2'd2) ? 2'd0 : a + 2'd1;
		else
			n = 2'd3 - a - b;
		return n;
	endfunction

	always_ff @(posedge CLK_VIDEO) begin
		if (!i_rst_n) begin
			o_wr_buf <= '0;
			rd_buf   <= '0;
			vs_d     <= 1'b0;
			vbl_d    <= 1'b0;
		end else begin
			vs_d  <= i_vs;
			vbl_d <= i_fb_vbl;
			if (i_vs && !vs_d)
				o_wr_buf <= i_low_lat ? {1'b0, ~o_wr_buf[0]} : third_buf(o_wr_buf, rd_buf);
			if (i_fb_vbl && !vbl_d)
				rd_buf <= i_low_lat ? {1'b0, ~o_wr_buf[0]} : third_buf(rd_buf, o_wr_buf);
		end
	end

	assign o_fb_base = MEM_BASE
		+ {{(ADR_W-BUF_W){1'b0}}, rd_buf} * video_rotate_pkg::BUF_BYTES;

endmodule

// File: src/arcade_rotate_top.sv
// Video back end that rotates the arcade picture into a framebuffer.
// The framebuffer holds one 32-bit word per pixel, three buffers of 8 MB
// each from MEM_BASE.
// Width and height describe the rotated picture, i.e. the source line count
// and line length of the previous frame.
// Pixels are dropped when the bus falls behind, and o_overflow records it.

`timescale 1ns/1ps

module arcade_rotate_top #(
	parameter int                                 DW         = 8,
	parameter logic [video_rotate_pkg::ADR_W-1:0] MEM_BASE   = 32'h2400_0000,
	parameter int                                 FIFO_DEPTH = 16
) (
	input  logic                                 CLK_VIDEO,
	input  logic                                 i_rst_n,
	input  logic                                 i_ce_pix,
	input  logic [DW-1:0]                        i_rgb,
	input  logic                                 i_hblank,
	input  logic                                 i_vblank,
	input  logic                                 i_hsync,
	input  logic                                 i_vsync,
	input  logic                                 i_rotate_ccw,
	input  logic                                 i_low_lat,
	input  logic                                 i_fb_vbl,
	output logic                                 o_wb_cyc,
	output logic                                 o_wb_stb,
	output logic                                 o_wb_we,
	output logic [video_rotate_pkg::WORD_W/8-1:0] o_wb_sel,
	output logic [video_rotate_pkg::ADR_W-1:0]    o_wb_adr,
	output logic [video_rotate_pkg::WORD_W-1:0]   o_wb_dat,
	input  logic                                 i_wb_ack,
	output logic [video_rotate_pkg::DIM_W-1:0]    o_fb_width,
	output logic [video_rotate_pkg::DIM_W-1:0]    o_fb_height,
	output logic [video_rotate_pkg::DIM_W+1:0]    o_fb_stride,
	output logic [video_rotate_pkg::ADR_W-1:0]    o_fb_base,
	output logic                                 o_overflow
);

	localparam int PIX_W = video_rotate_pkg::PIX_W;
	localparam int OFS_W = video_rotate_pkg::OFS_W;
	localparam int DIM_W = video_rotate_pkg::DIM_W;
	localparam int BUF_W = video_rotate_pkg::BUF_W;
	localparam int ENT_W = OFS_W + PIX_W;

	logic             hs_fix;
	logic             vs_fix;
	logic             pix_stb;
	logic [PIX_W-1:0] pix_rgb;
	logic             pix_vs;
	logic             pix_de;
	logic [DIM_W-1:0] line_len;
	logic [DIM_W-1:0] line_cnt;
	logic [DIM_W-1:0] stride;
	logic [OFS_W-1:0] buf_words;
	logic             push;
	logic             fifo_push;
	logic [OFS_W-1:0] push_ofs;
	logic [PIX_W-1:0] push_rgb;
	logic [ENT_W-1:0] fifo_data;
	logic             fifo_empty;
	logic             fifo_pop;
	logic [BUF_W-1:0] wr_buf;

	//============================================================
	// Input stage
	//============================================================

	sync_polarity_fix u_hs_fix (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(i_rst_n), .i_sync(i_hsync), .o_sync(hs_fix)
	);

	sync_polarity_fix u_vs_fix (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(i_rst_n), .i_sync(i_vsync), .o_sync(vs_fix)
	);

	// The captured HS is only needed inside the capture stage
	pixel_capture #(.DW(DW)) u_capture (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(i_rst_n), .i_ce_pix(i_ce_pix),
		.i_rgb(i_rgb), .i_hblank(i_hblank), .i_vblank(i_vblank),
		.i_hs(hs_fix), .i_vs(vs_fix),
		.o_pix_stb(pix_stb), .o_rgb(pix_rgb), .o_hs(), .o_vs(pix_vs), .o_de(pix_de)
	);

	//============================================================
	// Geometry and addressing
	//============================================================

	frame_measure u_measure (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(i_rst_n), .i_pix_stb(pix_stb),
		.i_vs(pix_vs), .i_de(pix_de),
		.o_line_len(line_len), .o_line_cnt(line_cnt),
		.o_stride_words(stride), .o_buf_words(buf_words)
	);

	rotate_addr_gen u_addr (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(i_rst_n), .i_pix_stb(pix_stb),
		.i_rgb(pix_rgb), .i_vs(pix_vs), .i_de(pix_de), .i_rotate_ccw(i_rotate_ccw),
		.i_line_len(line_len), .i_line_cnt(line_cnt), .i_stride_words(stride),
		.o_push(push), .o_push_ofs(push_ofs), .o_push_rgb(push_rgb)
	);

	// When the size changes a pixel can fall past the buffer end
	// Such a pixel is dropped so that it cannot overwrite the next buffer
	assign fifo_push = push && (push_ofs < buf_words);

	//============================================================
	// Memory side
	//============================================================

	pixel_fifo #(.WIDTH(ENT_W), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(i_rst_n), .i_push(fifo_push),
		.i_data({push_ofs, push_rgb}), .i_pop(fifo_pop),
		.o_data(fifo_data), .o_empty(fifo_empty), .o_overflow(o_overflow)
	);

	wb_pixel_writer #(.MEM_BASE(MEM_BASE)) u_writer (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(i_rst_n), .i_empty(fifo_empty),
		.i_data(fifo_data), .i_buf_idx(wr_buf), .o_pop(fifo_pop),
		.o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
		.o_wb_sel(o_wb_sel), .o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat),
		.i_wb_ack(i_wb_ack)
	);

	fb_buffer_select #(.MEM_BASE(MEM_BASE)) u_bufsel (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(i_rst_n), .i_vs(pix_vs),
		.i_fb_vbl(i_fb_vbl), .i_low_lat(i_low_lat),
		.o_wr_buf(wr_buf), .o_fb_base(o_fb_base)
	);

	// The rotated picture swaps the two source dimensions
	assign o_fb_width  = line_cnt;
	assign o_fb_height = line_len;
	assign o_fb_stride = {stride, 2'b00};

endmodule

// File: tests/tb_wb_memory.sv
// Wishbone classic slave memory for the testbench.
// Words are kept in an associative array indexed by byte address.
// The acknowledge follows the strobe after i_ack_delay wait cycles, and
// a delay of zero acknowledges in the same cycle.
// Only whole-word writes with all byte selects set are stored and counted.

`timescale 1ns/1ps

module tb_wb_memory (
	input  logic        CLK_VIDEO,
	input  logic        i_rst_n,
	input  logic        i_clear,
	input  logic [7:0]  i_ack_delay,
	input  logic        i_wb_cyc,
	input  logic        i_wb_stb,
	input  logic        i_wb_we,
	input  logic [3:0]  i_wb_sel,
	input  logic [31:0] i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic        o_wb_ack,
	output int          o_write_count
);

	logic [31:0] mem [logic [31:0]];
	logic [7:0]  wait_cnt;

	assign o_wb_ack = i_wb_cyc && i_wb_stb && (wait_cnt >= i_ack_delay);

	always @(posedge CLK_VIDEO) begin
		// Wait cycles count only while a strobe is pending
		if (!i_rst_n || !(i_wb_cyc && i_wb_stb) || o_wb_ack)
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 1'b1;
		if (i_clear) begin
			mem.delete();
			o_write_count = 0;
		end else if (o_wb_ack && i_wb_we && (&i_wb_sel)) begin
			mem[i_wb_adr] = i_wb_dat;
			o_write_count = o_write_count + 1;
		end
	end

endmodule

// File: tests/tb_arcade_rotate.sv
// Directed testbench for the rotating video back end.
// Frames are small, with the pixel enable high every other clock.
// Each frame has three blanking lines, the second carrying VS, and four
// blanking pixels per line, the second carrying HS.
// Inputs change on the falling edge and outputs are read there too.

`timescale 1ns/1ps

module tb_arcade_rotate;

	localparam logic [31:0] MEM_BASE = 32'h2000_0000;

	logic        CLK_VIDEO;
	logic        rst_n;
	logic        ce_pix;
	logic [7:0]  rgb;
	logic        hblank;
	logic        vblank;
	logic        hsync;
	logic        vsync;
	logic        rotate_ccw;
	logic        low_lat;
	logic        fb_vbl;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_sel;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat;
	logic        wb_ack;
	logic [11:0] fb_width;
	logic [11:0] fb_height;
	logic [13:0] fb_stride;
	logic [31:0] fb_base;
	logic        overflow;
	logic        mem_clear;
	logic [7:0]  ack_delay;
	int          write_count;

	int          errors;
	logic [31:0] rng;
	logic        sync_low;
	logic [1:0]  wr_model;
	logic [1:0]  rd_model;
	logic [7:0]  exp_rgb [0:63];

	arcade_rotate_top #(.DW(8), .MEM_BASE(MEM_BASE), .FIFO_DEPTH(8)) UUT (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(rst_n), .i_ce_pix(ce_pix), .i_rgb(rgb),
		.i_hblank(hblank), .i_vblank(vblank), .i_hsync(hsync), .i_vsync(vsync),
		.i_rotate_ccw(rotate_ccw), .i_low_lat(low_lat), .i_fb_vbl(fb_vbl),
		.o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we), .o_wb_sel(wb_sel),
		.o_wb_adr(wb_adr), .o_wb_dat(wb_dat), .i_wb_ack(wb_ack),
		.o_fb_width(fb_width), .o_fb_height(fb_height), .o_fb_stride(fb_stride),
		.o_fb_base(fb_base), .o_overflow(overflow)
	);

	tb_wb_memory u_mem (
		.CLK_VIDEO(CLK_VIDEO), .i_rst_n(rst_n), .i_clear(mem_clear),
		.i_ack_delay(ack_delay), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb),
		.i_wb_we(wb_we), .i_wb_sel(wb_sel), .i_wb_adr(wb_adr), .i_wb_dat(wb_dat),
		.o_wb_ack(wb_ack), .o_write_count(write_count)
	);

	initial begin
		CLK_VIDEO = 1'b0;
		forever #2 CLK_VIDEO = ~CLK_VIDEO;
	end

	//============================================================
	// Reference rules
	//============================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// 3-3-2 packing with red on top, stored as {blue, green, red}
	function automatic logic [31:0] expand_332(input logic [7:0] p);
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		r = p[7:5];
		g = p[4:2];
		b = p[1:0];
		return {8'h00, b, b, b, b, g, g, g[2:1], r, r, r[2:1]};
	endfunction

	// The buffer that neither index holds, or the next one when both agree
	function automatic logic [1:0] free_buf(input logic [1:0] a, input logic [1:0] b);
		logic [1:0] n;
		n = (a == 2'd2) ? 2'd0 : a + 2'd1;
		if (a != b) begin
			for (int i = 0; i < 3; i++)
				if (i != a && i != b)
					n = 2'(i);
		end
		return n;
	endfunction

	//============================================================
	// Stimulus helpers
	//============================================================

	task automatic apply_reset;
		@(negedge CLK_VIDEO);
		rst_n     = 1'b0;
		ce_pix    = 1'b0;
		hblank    = 1'b1;
		vblank    = 1'b1;
		hsync     = sync_low;
		vsync     = sync_low;
		fb_vbl    = 1'b0;
		mem_clear = 1'b1;
		repeat (5) @(negedge CLK_VIDEO);
		rst_n     = 1'b1;
		mem_clear = 1'b0;
		wr_model  = 2'd0;
		rd_model  = 2'd0;
		@(negedge CLK_VIDEO);
		if (wb_cyc || wb_stb || overflow || fb_base != MEM_BASE) begin
			$display("mismatch at %0t: bus, overflow or buffer base not at reset values",
				$time);
			errors++;
		end
	endtask

	task automatic clear_memory;
		@(negedge CLK_VIDEO);
		mem_clear = 1'b1;
		@(negedge CLK_VIDEO);
		mem_clear = 1'b0;
	endtask

	// Blanking lines first, so VS opens the frame
	task automatic send_frame(input int w, input int h);
		for (int l = 0; l < h + 3; l++) begin
			for (int s = 0; s < w + 4; s++) begin
				@(negedge CLK_VIDEO);
				ce_pix = 1'b1;
				hblank = (s >= w);
				vblank = (l < 3);
				hsync  = (s == w + 1) ^ sync_low;
				vsync  = (l == 1) ^ sync_low;
				if (l >= 3 && s < w) begin
					rng = xorshift32(rng);
					rgb = rng[7:0];
					exp_rgb[(l-3)*w+s] = rng[7:0];
				end else begin
					rgb = 8'h00;
				end
				@(negedge CLK_VIDEO);
				ce_pix = 1'b0;
			end
		end
		wr_model = low_lat ? (wr_model[0] ? 2'd0 : 2'd1) : free_buf(wr_model, rd_model);
	endtask

	task automatic pulse_vbl;
		@(negedge CLK_VIDEO);
		fb_vbl = 1'b1;
		@(negedge CLK_VIDEO);
		fb_vbl = 1'b0;
		rd_model = low_lat ? (wr_model[0] ? 2'd0 : 2'd1) : free_buf(rd_model, wr_model);
	endtask

	task automatic wait_writes(input int n);
		int t;
		t = 0;
		while (write_count < n && t < 4000) begin
			@(negedge CLK_VIDEO);
			t++;
		end
		if (write_count < n) begin
			$display("timed out with %0d of %0d pixel writes done", write_count, n);
			errors++;
		end
	endtask

	//============================================================
	// Tests
	//============================================================

	// Second frame is placed with measured geometry and checked word by word
	task automatic check_rotation(input logic ccw, input logic act_low);
		int          w;
		int          h;
		int          stride;
		logic [31:0] ofs;
		logic [31:0] adr;
		logic [31:0] exp;
		w = 6;
		h = 5;
		sync_low   = act_low;
		rotate_ccw = ccw;
		low_lat    = 1'b0;
		ack_delay  = 8'd0;
		apply_reset();
		send_frame(w, h);
		wait_writes(w * h);
		clear_memory();
		send_frame(w, h);
		wait_writes(w * h);
		repeat (20) @(negedge CLK_VIDEO);
		if (write_count != w * h) begin
			$display("mismatch at %0t: frame gave %0d writes instead of %0d", $time,
				write_count, w * h);
			errors++;
		end
		stride = (h + 3) / 4 * 4;
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				ofs = ccw ? (w - 1 - x) * stride + y : x * stride + (h - 1 - y);
				adr = MEM_BASE + 32'(wr_model) * video_rotate_pkg::BUF_BYTES + ofs * 4;
				exp = expand_332(exp_rgb[y*w+x]);
				if (!u_mem.mem.exists(adr)) begin
					$display("pixel x %0d y %0d never reached address %h", x, y, adr);
					errors++;
				end else if (u_mem.mem[adr] != exp) begin
					$display("mismatch at %0t: pixel x %0d y %0d got %h expected %h",
						$time, x, y, u_mem.mem[adr], exp);
					errors++;
				end
			end
		end
		if (fb_width != h || fb_height != w || fb_stride != stride * 4) begin
			$display("mismatch at %0t: geometry %0d x %0d stride %0d", $time,
				fb_width, fb_height, fb_stride);
			errors++;
		end
		if (overflow) begin
			$display("mismatch at %0t: overflow flag set with an immediate acknowledge",
				$time);
			errors++;
		end
	endtask

	task automatic check_base;
		logic [31:0] exp;
		repeat (3) @(negedge CLK_VIDEO);
		exp = MEM_BASE + 32'(rd_model) * video_rotate_pkg::BUF_BYTES;
		if (fb_base != exp) begin
			$display("mismatch at %0t: fb_base %h expected %h", $time, fb_base, exp);
			errors++;
		end
	endtask

	task automatic check_buffering(input logic ll);
		sync_low  = 1'b0;
		low_lat   = ll;
		ack_delay = 8'd0;
		apply_reset();
		repeat (3) begin
			send_frame(4, 0);
			check_base();
			pulse_vbl();
			check_base();
			pulse_vbl();
			check_base();
		end
		low_lat = 1'b0;
	endtask

	task automatic check_backpressure;
		sync_low   = 1'b0;
		rotate_ccw = 1'b0;
		ack_delay  = 8'd30;
		apply_reset();
		send_frame(6, 5);
		repeat (4) @(negedge CLK_VIDEO);
		if (!overflow) begin
			$display("mismatch at %0t: overflow flag stayed clear under a slow acknowledge",
				$time);
			errors++;
		end
		ack_delay = 8'd0;
		apply_reset();
		send_frame(6, 5);
		wait_writes(30);
		if (overflow) begin
			$display("mismatch at %0t: overflow flag set for a frame the bus could keep up with",
				$time);
			errors++;
		end
	endtask

	initial begin
		errors     = 0;
		rng        = 32'h86c135fc;
		rst_n      = 1'b0;
		ce_pix     = 1'b0;
		rgb        = 8'h00;
		hblank     = 1'b1;
		vblank     = 1'b1;
		hsync      = 1'b0;
		vsync      = 1'b0;
		rotate_ccw = 1'b0;
		low_lat    = 1'b0;
		fb_vbl     = 1'b0;
		mem_clear  = 1'b0;
		ack_delay  = 8'd0;
		sync_low   = 1'b0;
		wr_model   = 2'd0;
		rd_model   = 2'd0;
		check_rotation(1'b0, 1'b0);
		check_rotation(1'b1, 1'b0);
		check_rotation(1'b1, 1'b1);
		check_rotation(1'b0, 1'b1);
		check_buffering(1'b0);
		check_buffering(1'b1);
		check_backpressure();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: files.f
src/video_rotate_pkg.sv
src/sync_polarity_fix.sv
src/pixel_capture.sv
src/frame_measure.sv
src/rotate_addr_gen.sv
src/pixel_fifo.sv
src/wb_pixel_writer.sv
src/fb_buffer_select.sv
src/arcade_rotate_top.sv
tests/tb_wb_memory.sv
tests/tb_arcade_rotate.sv

// File: Bender.yml
package:
  name: arcade_rotate

sources:
  - src/video_rotate_pkg.sv
  - src/sync_polarity_fix.sv
  - src/pixel_capture.sv
  - src/frame_measure.sv
  - src/rotate_addr_gen.sv
  - src/pixel_fifo.sv
  - src/wb_pixel_writer.sv
  - src/fb_buffer_select.sv
  - src/arcade_rotate_top.sv
  - target: test
    files:
      - tests/tb_wb_memory.sv
      - tests/tb_arcade_rotate.sv
